// File: design/rvdec_ctrl_fsm.sv
////////////////////////////////////////////////////////////
// Decode stage controller
//   RUN, DIV_WAIT and SLEEP states
//   Ready, accept and side effect deassertion
//   Divide stall timer load, WFI sleep
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rvdec_ctrl_fsm (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic instr_valid_i,
  input  logic trap_i,          // Decoded illegal, ECALL or EBREAK
  input  logic div_en_i,        // Raw divide enable
  input  logic wfi_i,           // Raw WFI flag
  input  logic irq_i,           // Wakeup from SLEEP
  input  logic timer_done_i,    // Last divide stall cycle
  output logic ready_o,
  output logic deassert_we_o,
  output logic accept_o,
  output logic timer_load_o,
  output logic sleep_o
);

  typedef enum logic [1:0] {
    ST_RUN,
    ST_DIV_WAIT,
    ST_SLEEP
  } state_e;

  state_e state_q;
  state_e state_d;

  assign ready_o       = (state_q == ST_RUN);
  assign accept_o      = instr_valid_i & ready_o;
  assign deassert_we_o = ~accept_o | trap_i;              // Kill side effects
  assign timer_load_o  = accept_o & ~trap_i & div_en_i;   // Start the divide stall
  assign sleep_o       = (state_q == ST_SLEEP);

  ////////////////////////////////////////////////////////////
  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_RUN: begin
        if (timer_load_o) begin
          state_d = ST_DIV_WAIT;
        end else if (accept_o && !trap_i && wfi_i) begin
          state_d = ST_SLEEP;                  // Sleeps at least one cycle
        end
      end
      ST_DIV_WAIT: begin
        if (timer_done_i) state_d = ST_RUN;
      end
      ST_SLEEP: begin
        if (irq_i) state_d = ST_RUN;
      end
      default: state_d = ST_RUN;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // Timer ends a stall only while the FSM waits on it
  timer_done_wait_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    timer_done_i |-> (state_q == ST_DIV_WAIT))
    else $error("Timer done outside DIV_WAIT");

  // Accepted WFI sleeps on the very next cycle
  wfi_sleep_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (accept_o && wfi_i && !trap_i) |=> sleep_o && !ready_o)
    else $error("WFI did not enter sleep");

endmodule

// File: design/rvdec_decoder.sv
////////////////////////////////////////////////////////////
// Decoder wrapper
//   RV32I and RV32M sub-decoders
//   Priority mux with illegal compressed override
//   Side effect deassertion and raw stall/trap flags
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rvdec_decoder import rvdec_pkg::*; (
  input  logic          deassert_we_i,      // Stage not accepting, or trapping
  input  logic [31:0]   instr_rdata_i,
  input  logic          illegal_c_insn_i,   // Compressed expansion failed
  output decoder_ctrl_t ctrl_o,             // Record after deassertion
  output logic          div_en_raw_o,       // Before deassertion, for the FSM
  output logic          wfi_raw_o,
  output logic          trap_o              // Illegal, ECALL or EBREAK
);

  decoder_ctrl_t decoder_i_ctrl;
  decoder_ctrl_t decoder_m_ctrl;
  decoder_ctrl_t decoder_ctrl_mux;

  rvdec_i_decoder i_decoder_inst (
    .instr_rdata_i  (instr_rdata_i),
    .decoder_ctrl_o (decoder_i_ctrl)
  );

  rvdec_m_decoder m_decoder_inst (
    .instr_rdata_i  (instr_rdata_i),
    .decoder_ctrl_o (decoder_m_ctrl)
  );

  // Compressed failure wins, then M, then I
  always_comb begin
    if (illegal_c_insn_i) begin
      decoder_ctrl_mux = DECODER_CTRL_ILLEGAL_INSN;
    end else if (!decoder_m_ctrl.illegal_insn) begin
      decoder_ctrl_mux = decoder_m_ctrl;
    end else if (!decoder_i_ctrl.illegal_insn) begin
      decoder_ctrl_mux = decoder_i_ctrl;
    end else begin
      decoder_ctrl_mux = DECODER_CTRL_ILLEGAL_INSN;   // Nobody matched
    end
  end

  ////////////////////////////////////////////////////////////
  // Deassertion, trap flags pass untouched
  always_comb begin
    ctrl_o = decoder_ctrl_mux;
    if (deassert_we_i) begin
      ctrl_o.alu_en             = 1'b0;
      ctrl_o.mult_en            = 1'b0;
      ctrl_o.div_en             = 1'b0;
      ctrl_o.rf_we              = 1'b0;
      ctrl_o.data_req           = 1'b0;
      ctrl_o.csr_op             = CSR_OP_READ;   // A read has no CSR side effect
      ctrl_o.ctrl_transfer_insn = BRANCH_NONE;
    end
  end

  assign div_en_raw_o = decoder_ctrl_mux.div_en;
  assign wfi_raw_o    = decoder_ctrl_mux.wfi_insn;
  assign trap_o       = decoder_ctrl_mux.illegal_insn | decoder_ctrl_mux.ecall_insn |
                        decoder_ctrl_mux.ebrk_insn;

  // Sub-decoder encodings must be disjoint
  always_comb begin
    assert final (decoder_m_ctrl.illegal_insn || decoder_i_ctrl.illegal_insn)
      else $error("I and M decoders both matched %h", instr_rdata_i);
  end

endmodule

// File: design/rvdec_i_decoder.sv
////////////////////////////////////////////////////////////
// RV32I base instruction decoder
//   Upper immediates, jumps, branches, loads, stores
//   Register and immediate ALU ops, FENCE, FENCE.I
//   CSR access, ECALL, EBREAK, MRET, WFI
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rvdec_i_decoder import rvdec_pkg::*; (
  input  logic [31:0]   instr_rdata_i,    // Instruction word from IF/ID
  output decoder_ctrl_t decoder_ctrl_o    // Illegal record on no match
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       illegal;                    // Set by any unmatched field

  assign opcode = instr_rdata_i[6:0];
  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];

  always_comb begin
    decoder_ctrl_o              = DECODER_CTRL_ILLEGAL_INSN;
    decoder_ctrl_o.illegal_insn = 1'b0;   // Cleared, restored below on a miss
    illegal                     = 1'b0;

    case (opcode)
      OPCODE_LUI, OPCODE_AUIPC: begin     // Immediate (plus PC) through the adder
        decoder_ctrl_o.alu_en = 1'b1;
        decoder_ctrl_o.rf_we  = 1'b1;
      end
      OPCODE_JAL: begin                   // Link address from the adder
        decoder_ctrl_o.ctrl_transfer_insn = BRANCH_JAL;
        decoder_ctrl_o.alu_en             = 1'b1;
        decoder_ctrl_o.rf_we              = 1'b1;
      end
      OPCODE_JALR: begin
        decoder_ctrl_o.ctrl_transfer_insn = BRANCH_JALR;
        decoder_ctrl_o.alu_en             = 1'b1;
        decoder_ctrl_o.rf_we              = 1'b1;
        illegal                           = (funct3 != 3'b000);
      end
      OPCODE_BRANCH: begin                // Condition evaluated in the ALU
        decoder_ctrl_o.ctrl_transfer_insn = BRANCH_COND;
        decoder_ctrl_o.alu_en             = 1'b1;
        case (funct3)
          3'b000:  decoder_ctrl_o.alu_operator = ALU_EQ;
          3'b001:  decoder_ctrl_o.alu_operator = ALU_NE;
          3'b100:  decoder_ctrl_o.alu_operator = ALU_LT;
          3'b101:  decoder_ctrl_o.alu_operator = ALU_GE;
          3'b110:  decoder_ctrl_o.alu_operator = ALU_LTU;
          3'b111:  decoder_ctrl_o.alu_operator = ALU_GEU;
          default: illegal = 1'b1;        // 010, 011 reserved
        endcase
      end
      OPCODE_LOAD: begin
        decoder_ctrl_o.data_req      = 1'b1;
        decoder_ctrl_o.rf_we         = 1'b1;
        decoder_ctrl_o.data_type     = funct3[1:0];
        decoder_ctrl_o.data_sign_ext = ~funct3[2];   // LBU, LHU zero extend
        illegal = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end
      OPCODE_STORE: begin                 // SB, SH, SW only
        decoder_ctrl_o.data_req  = 1'b1;
        decoder_ctrl_o.data_we   = 1'b1;
        decoder_ctrl_o.data_type = funct3[1:0];
        illegal = funct3[2] || (funct3[1:0] == 2'b11);
      end
      OPCODE_OP_IMM: begin
        decoder_ctrl_o.alu_en = 1'b1;
        decoder_ctrl_o.rf_we  = 1'b1;
        case (funct3)
          3'b000: decoder_ctrl_o.alu_operator = ALU_ADD;    // ADDI
          3'b010: decoder_ctrl_o.alu_operator = ALU_SLT;    // SLTI
          3'b011: decoder_ctrl_o.alu_operator = ALU_SLTU;   // SLTIU
          3'b100: decoder_ctrl_o.alu_operator = ALU_XOR;
          3'b110: decoder_ctrl_o.alu_operator = ALU_OR;
          3'b111: decoder_ctrl_o.alu_operator = ALU_AND;
          3'b001: begin                                     // SLLI
            decoder_ctrl_o.alu_operator = ALU_SLL;
            illegal = (funct7 != 7'b0);
          end
          default: begin                                    // SRLI, SRAI
            decoder_ctrl_o.alu_operator = funct7[5] ? ALU_SRA : ALU_SRL;
            illegal = ({funct7[6], funct7[4:0]} != 6'b0);
          end
        endcase
      end
      OPCODE_OP: begin
        decoder_ctrl_o.alu_en = 1'b1;
        decoder_ctrl_o.rf_we  = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: decoder_ctrl_o.alu_operator = ALU_ADD;
          {7'h20, 3'b000}: decoder_ctrl_o.alu_operator = ALU_SUB;
          {7'h00, 3'b001}: decoder_ctrl_o.alu_operator = ALU_SLL;
          {7'h00, 3'b010}: decoder_ctrl_o.alu_operator = ALU_SLT;
          {7'h00, 3'b011}: decoder_ctrl_o.alu_operator = ALU_SLTU;
          {7'h00, 3'b100}: decoder_ctrl_o.alu_operator = ALU_XOR;
          {7'h00, 3'b101}: decoder_ctrl_o.alu_operator = ALU_SRL;
          {7'h20, 3'b101}: decoder_ctrl_o.alu_operator = ALU_SRA;
          {7'h00, 3'b110}: decoder_ctrl_o.alu_operator = ALU_OR;
          {7'h00, 3'b111}: decoder_ctrl_o.alu_operator = ALU_AND;
          default:         illegal = 1'b1;  // MUL/DIV belong to the M decoder
        endcase
      end
      OPCODE_MISC_MEM: begin              // FENCE has no effect in order
        decoder_ctrl_o.fencei_insn = (funct3 == 3'b001);
        illegal                    = (funct3[2:1] != 2'b00);
      end
      OPCODE_SYSTEM: begin
        if (funct3 == 3'b000) begin       // Privileged group, rs1 and rd zero
          illegal = (instr_rdata_i[19:7] != 13'b0);
          case (instr_rdata_i[31:20])
            12'h000: decoder_ctrl_o.ecall_insn = 1'b1;
            12'h001: decoder_ctrl_o.ebrk_insn  = 1'b1;
            12'h302: decoder_ctrl_o.mret_insn  = 1'b1;
            12'h105: decoder_ctrl_o.wfi_insn   = 1'b1;
            default: illegal = 1'b1;      // DRET included, no debug mode
          endcase
        end else begin                    // CSRRW/S/C and immediate forms
          decoder_ctrl_o.csr_en = 1'b1;
          decoder_ctrl_o.rf_we  = 1'b1;
          decoder_ctrl_o.csr_op = csr_opcode_e'(funct3[1:0]);
          illegal               = (funct3 == 3'b100);
        end
      end
      default: illegal = 1'b1;
    endcase

    if (illegal) begin
      decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;   // Drop any partial decode
    end
  end

endmodule

// File: design/rvdec_id_ex_reg.sv
////////////////////////////////////////////////////////////
// ID/EX pipeline register
//   Valid bit and decoder control record
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rvdec_id_ex_reg import rvdec_pkg::*; (
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  logic          accept_i,     // Instruction taken this cycle
  input  decoder_ctrl_t ctrl_i,       // Already deasserted
  output logic          ex_valid_o,
  output decoder_ctrl_t ex_ctrl_o
);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_valid_o <= 1'b0;
      ex_ctrl_o  <= '0;                            // No flags, no enables
    end else begin
      ex_valid_o <= accept_i;
      ex_ctrl_o  <= accept_i ? ctrl_i : '0;        // Bubble on idle cycles
    end
  end

endmodule

// File: design/rvdec_id_stage.sv
////////////////////////////////////////////////////////////
// Decode stage top
//   Decoder, controller FSM, divide stall timer
//   ID/EX register towards execute
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rvdec_id_stage import rvdec_pkg::*; (
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  logic          instr_valid_i,
  input  logic [31:0]   instr_rdata_i,
  input  logic          illegal_c_insn_i,
  input  logic          irq_i,
  output logic          ready_o,
  output logic          sleep_o,
  output logic          ex_valid_o,
  output decoder_ctrl_t ex_ctrl_o
);

  decoder_ctrl_t id_ctrl;       // Deasserted record into ID/EX
  logic          deassert_we;
  logic          div_en_raw;
  logic          wfi_raw;
  logic          trap;
  logic          accept;
  logic          timer_load;
  logic          timer_done;

  rvdec_decoder decoder_inst (
    .deassert_we_i    (deassert_we),
    .instr_rdata_i    (instr_rdata_i),
    .illegal_c_insn_i (illegal_c_insn_i),
    .ctrl_o           (id_ctrl),
    .div_en_raw_o     (div_en_raw),
    .wfi_raw_o        (wfi_raw),
    .trap_o           (trap)
  );

  rvdec_ctrl_fsm ctrl_fsm_inst (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .trap_i        (trap),
    .div_en_i      (div_en_raw),
    .wfi_i         (wfi_raw),
    .irq_i         (irq_i),
    .timer_done_i  (timer_done),
    .ready_o       (ready_o),
    .deassert_we_o (deassert_we),
    .accept_o      (accept),
    .timer_load_o  (timer_load),
    .sleep_o       (sleep_o)
  );

  rvdec_stall_timer stall_timer_inst (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .load_i   (timer_load),
    .done_o   (timer_done)
  );

  rvdec_id_ex_reg id_ex_reg_inst (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .accept_i   (accept),
    .ctrl_i     (id_ctrl),
    .ex_valid_o (ex_valid_o),
    .ex_ctrl_o  (ex_ctrl_o)
  );

endmodule

// File: design/rvdec_m_decoder.sv
////////////////////////////////////////////////////////////
// RV32M decoder
//   MUL, MULH, MULHSU, MULHU to the multiplier
//   DIV, DIVU, REM, REMU to the divider
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rvdec_m_decoder import rvdec_pkg::*; (
  input  logic [31:0]   instr_rdata_i,    // Instruction word from IF/ID
  output decoder_ctrl_t decoder_ctrl_o    // Illegal record on no match
);

  logic [2:0] funct3;

  assign funct3 = instr_rdata_i[14:12];

  always_comb begin
    decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
    if (instr_rdata_i[6:0] == OPCODE_OP && instr_rdata_i[31:25] == 7'b0000001) begin
      decoder_ctrl_o.illegal_insn = 1'b0;
      decoder_ctrl_o.rf_we        = 1'b1;
      if (!funct3[2]) begin               // Multiply half
        decoder_ctrl_o.mult_en       = 1'b1;
        decoder_ctrl_o.mult_operator = (funct3 == 3'b000) ? MUL_M32 : MUL_H;
        case (funct3[1:0])
          2'b01:   decoder_ctrl_o.mult_signed_mode = 2'b11;   // MULH
          2'b10:   decoder_ctrl_o.mult_signed_mode = 2'b01;   // MULHSU, rs1 signed
          default: decoder_ctrl_o.mult_signed_mode = 2'b00;   // MUL, MULHU
        endcase
      end else begin                      // Divide half
        decoder_ctrl_o.div_en       = 1'b1;
        decoder_ctrl_o.div_operator = div_opcode_e'(funct3[1:0]);
      end
    end
  end

endmodule

// File: design/rvdec_pkg.sv
////////////////////////////////////////////////////////////
// Decode stage shared definitions
//   RV32 major opcodes used by the sub-decoders
//   ALU, multiply, divide, CSR and control transfer encodings
//   Decoder control record and its illegal default
//   Divide stall latency and stall counter width
////////////////////////////////////////////////////////////

package rvdec_pkg;

  ////////////////////////////////////////////////////////////
  // Major opcodes, instr[6:0]
  ////////////////////////////////////////////////////////////
  localparam logic [6:0] OPCODE_LOAD     = 7'h03;
  localparam logic [6:0] OPCODE_MISC_MEM = 7'h0f;  // FENCE, FENCE.I
  localparam logic [6:0] OPCODE_OP_IMM   = 7'h13;
  localparam logic [6:0] OPCODE_AUIPC    = 7'h17;
  localparam logic [6:0] OPCODE_STORE    = 7'h23;
  localparam logic [6:0] OPCODE_OP       = 7'h33;  // Shared by RV32I and RV32M
  localparam logic [6:0] OPCODE_LUI      = 7'h37;
  localparam logic [6:0] OPCODE_BRANCH   = 7'h63;
  localparam logic [6:0] OPCODE_JALR     = 7'h67;
  localparam logic [6:0] OPCODE_JAL      = 7'h6f;
  localparam logic [6:0] OPCODE_SYSTEM   = 7'h73;  // CSR and privileged

  ////////////////////////////////////////////////////////////
  // Operation encodings
  ////////////////////////////////////////////////////////////
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB,                  // Arithmetic
    ALU_XOR, ALU_OR, ALU_AND,          // Logic
    ALU_SLL, ALU_SRL, ALU_SRA,         // Shifts
    ALU_SLT, ALU_SLTU,                 // Set less than
    ALU_EQ, ALU_NE, ALU_LT,            // Branch compares
    ALU_GE, ALU_LTU, ALU_GEU
  } alu_opcode_e;

  typedef enum logic {
    MUL_M32,                           // Low word
    MUL_H                              // High word, MULH/MULHSU/MULHU
  } mul_opcode_e;

  // Order follows funct3[1:0] of the divide group
  typedef enum logic [1:0] {
    DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU
  } div_opcode_e;

  // Order follows funct3[1:0] of the CSR group
  typedef enum logic [1:0] {
    CSR_OP_READ, CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR
  } csr_opcode_e;

  typedef enum logic [1:0] {
    BRANCH_NONE, BRANCH_JAL, BRANCH_JALR, BRANCH_COND
  } ctrl_transfer_e;

  ////////////////////////////////////////////////////////////
  // Decoder control record, 30 bits
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic           alu_en;
    alu_opcode_e    alu_operator;
    logic           mult_en;
    mul_opcode_e    mult_operator;
    logic [1:0]     mult_signed_mode;    // {rs2 signed, rs1 signed}
    logic           div_en;
    div_opcode_e    div_operator;
    logic           rf_we;               // Writes rd
    logic           data_req;            // Load or store
    logic           data_we;             // Store
    logic [1:0]     data_type;           // 00 byte, 01 half, 10 word
    logic           data_sign_ext;
    logic           csr_en;
    csr_opcode_e    csr_op;
    ctrl_transfer_e ctrl_transfer_insn;
    logic           illegal_insn;        // Also the no-match flag of a sub-decoder
    logic           ebrk_insn;
    logic           ecall_insn;
    logic           mret_insn;
    logic           wfi_insn;
    logic           fencei_insn;
  } decoder_ctrl_t;

  // No side effects, only the illegal flag
  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL_INSN = '{
    alu_en: 1'b0, alu_operator: ALU_ADD,
    mult_en: 1'b0, mult_operator: MUL_M32, mult_signed_mode: 2'b00,
    div_en: 1'b0, div_operator: DIV_DIV,
    rf_we: 1'b0,
    data_req: 1'b0, data_we: 1'b0, data_type: 2'b00, data_sign_ext: 1'b0,
    csr_en: 1'b0, csr_op: CSR_OP_READ,
    ctrl_transfer_insn: BRANCH_NONE,
    illegal_insn: 1'b1, ebrk_insn: 1'b0, ecall_insn: 1'b0,
    mret_insn: 1'b0, wfi_insn: 1'b0, fencei_insn: 1'b0
  };

  ////////////////////////////////////////////////////////////
  // Divide stall
  ////////////////////////////////////////////////////////////
  localparam int DIV_LATENCY = 4;                         // Stall cycles per divide
  localparam int DIV_CNT_W   = $clog2(DIV_LATENCY + 1);   // Holds 0..DIV_LATENCY

endpackage

// File: design/rvdec_stall_timer.sv
////////////////////////////////////////////////////////////
// Divide stall timer
//   Down-counter loaded with the divide latency
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rvdec_stall_timer import rvdec_pkg::*; (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic load_i,          // Accepted divide
  output logic done_o           // High on the last stall cycle
);

  logic [DIV_CNT_W-1:0] count_q;   // Stall cycles left, zero when idle

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else if (load_i) begin
      count_q <= DIV_CNT_W'(DIV_LATENCY);
    end else if (count_q != '0) begin
      count_q <= count_q - DIV_CNT_W'(1);
    end
  end

  assign done_o = (count_q == DIV_CNT_W'(1));

  // The FSM must not restart a running stall
  load_idle_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    load_i |-> (count_q == '0))
    else $error("Timer load while count is %0d", count_q);

endmodule

// File: run.sh
#!/bin/sh
# Compile and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f src.f --top-module rvdec_tb -o rvdec_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

./obj_dir/rvdec_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST OK$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: src.f
design/rvdec_pkg.sv
design/rvdec_i_decoder.sv
design/rvdec_m_decoder.sv
design/rvdec_decoder.sv
design/rvdec_ctrl_fsm.sv
design/rvdec_stall_timer.sv
design/rvdec_id_ex_reg.sv
design/rvdec_id_stage.sv
testbench/rvdec_tb.sv

// File: testbench/rvdec_tb.sv
////////////////////////////////////////////////////////////
// Decode stage testbench
//   Clock, reset and random instruction stream
//   Reference model of decode, divide stall and WFI sleep
//   Concurrent checks of the DUT against the model
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rvdec_tb import rvdec_pkg::*; ();

  localparam int CLK_PERIOD     = 40;
  localparam int RESET_CYCLES   = 10;
  localparam int NUM_ACCEPT     = 400;
  localparam int ACCEPT_TIMEOUT = 200;    // Cycles per instruction, sleep included

  // Stimulus table, K_CFLAG is any word with the compressed flag
  typedef enum int {
    K_ADD, K_SUB, K_ADDI, K_LW, K_SW, K_BEQ, K_JAL, K_CSRRW,
    K_MUL, K_DIV, K_ECALL, K_EBREAK, K_MRET, K_WFI, K_ILLEGAL, K_CFLAG
  } kind_e;

  typedef enum logic [1:0] {M_RUN, M_DIV, M_SLEEP} mstate_e;

  logic          clk;
  logic          arst_n;
  logic          instr_valid;
  logic [31:0]   instr_rdata;
  logic          illegal_c_insn;
  logic          irq;
  logic          ready;
  logic          sleep;
  logic          ex_valid;
  decoder_ctrl_t ex_ctrl;

  integer        seed;
  kind_e         cur_kind;                // Effective kind of the presented word

  // Model state
  mstate_e       m_state;
  int            m_stall_left;
  logic          m_accept;
  logic          exp_valid_q;
  decoder_ctrl_t exp_ctrl_q;
  int            accepted_count;

  rvdec_id_stage rvdec_id_stage_inst (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .instr_valid_i    (instr_valid),
    .instr_rdata_i    (instr_rdata),
    .illegal_c_insn_i (illegal_c_insn),
    .irq_i            (irq),
    .ready_o          (ready),
    .sleep_o          (sleep),
    .ex_valid_o       (ex_valid),
    .ex_ctrl_o        (ex_ctrl)
  );

  ////////////////////////////////////////////////////////////
  // Encodings and expected records
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] instr_word(kind_e k);
    case (k)
      K_ADD:    return 32'h003100b3;      // add x1, x2, x3
      K_SUB:    return 32'h403100b3;
      K_ADDI:   return 32'h00510093;      // addi x1, x2, 5
      K_LW:     return 32'h00012083;
      K_SW:     return 32'h00312023;
      K_BEQ:    return 32'h00208463;      // beq x1, x2, +8
      K_JAL:    return 32'h010000ef;      // jal x1, +16
      K_CSRRW:  return 32'h300110f3;      // csrrw x1, mstatus, x2
      K_MUL:    return 32'h023100b3;
      K_DIV:    return 32'h023140b3;
      K_ECALL:  return 32'h00000073;
      K_EBREAK: return 32'h00100073;
      K_MRET:   return 32'h30200073;
      K_WFI:    return 32'h10500073;
      default:  return 32'hffffffff;      // Reserved major opcode
    endcase
  endfunction

  // Record seen by execute after an accepted word of kind k
  function automatic decoder_ctrl_t expected_ctrl(kind_e k);
    decoder_ctrl_t c;
    c = '0;
    case (k)
      K_ADD, K_ADDI: begin
        c.alu_en = 1'b1;
        c.rf_we  = 1'b1;
      end
      K_SUB: begin
        c.alu_en       = 1'b1;
        c.alu_operator = ALU_SUB;
        c.rf_we        = 1'b1;
      end
      K_LW: begin
        c.data_req      = 1'b1;
        c.rf_we         = 1'b1;
        c.data_type     = 2'b10;          // Word
        c.data_sign_ext = 1'b1;
      end
      K_SW: begin
        c.data_req  = 1'b1;
        c.data_we   = 1'b1;
        c.data_type = 2'b10;
      end
      K_BEQ: begin
        c.alu_en             = 1'b1;
        c.alu_operator       = ALU_EQ;
        c.ctrl_transfer_insn = BRANCH_COND;
      end
      K_JAL: begin
        c.alu_en             = 1'b1;
        c.rf_we              = 1'b1;
        c.ctrl_transfer_insn = BRANCH_JAL;
      end
      K_CSRRW: begin
        c.csr_en = 1'b1;
        c.rf_we  = 1'b1;
        c.csr_op = CSR_OP_WRITE;
      end
      K_MUL: begin
        c.mult_en = 1'b1;                 // Low word, unsigned mode 00
        c.rf_we   = 1'b1;
      end
      K_DIV: begin
        c.div_en       = 1'b1;
        c.div_operator = DIV_DIV;
        c.rf_we        = 1'b1;
      end
      K_ECALL:  c.ecall_insn = 1'b1;      // Traps keep only their flag
      K_EBREAK: c.ebrk_insn  = 1'b1;
      K_MRET:   c.mret_insn  = 1'b1;
      K_WFI:    c.wfi_insn   = 1'b1;
      default:  c.illegal_insn = 1'b1;    // Illegal word or compressed flag
    endcase
    return c;
  endfunction

  function automatic logic [6:0] side_effects(decoder_ctrl_t c);
    return {c.alu_en, c.mult_en, c.div_en, c.rf_we, c.data_req, c.data_we, c.csr_en};
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////
  assign m_accept = instr_valid && (m_state == M_RUN);

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      m_state        <= M_RUN;
      m_stall_left   <= 0;
      exp_valid_q    <= 1'b0;
      exp_ctrl_q     <= '0;
      accepted_count <= 0;
    end else begin
      exp_valid_q <= m_accept;
      exp_ctrl_q  <= m_accept ? expected_ctrl(cur_kind) : '0;   // Bubble when idle
      if (m_accept) accepted_count <= accepted_count + 1;
      case (m_state)
        M_RUN: begin
          if (m_accept && cur_kind == K_DIV) begin
            m_state      <= M_DIV;
            m_stall_left <= DIV_LATENCY;
          end else if (m_accept && cur_kind == K_WFI) begin
            m_state <= M_SLEEP;
          end
        end
        M_DIV: begin
          if (m_stall_left == 1) m_state <= M_RUN;   // Last stall cycle
          m_stall_left <= m_stall_left - 1;
        end
        default: begin
          if (irq) m_state <= M_RUN;                 // Wakeup seen this edge
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic report_mismatch(input string sig, input logic [63:0] got,
                                 input logic [63:0] exp);
    fail_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h", $time, sig, got, exp));
  endtask

  reset_values_a: assert property (@(posedge clk) !arst_n |-> ready && !ex_valid && !sleep)
    else report_mismatch("{ready_o, ex_valid_o, sleep_o}",
                         64'({$sampled(ready), $sampled(ex_valid), $sampled(sleep)}),
                         64'(3'b100));

  ex_valid_a: assert property (@(posedge clk) disable iff (!arst_n) ex_valid == exp_valid_q)
    else report_mismatch("ex_valid_o", 64'($sampled(ex_valid)), 64'($sampled(exp_valid_q)));

  ex_ctrl_a: assert property (@(posedge clk) disable iff (!arst_n) ex_ctrl == exp_ctrl_q)
    else report_mismatch("ex_ctrl_o", 64'($sampled(ex_ctrl)), 64'($sampled(exp_ctrl_q)));

  // Divide stall and sleep both show on ready
  ready_a: assert property (@(posedge clk) disable iff (!arst_n) ready == (m_state == M_RUN))
    else report_mismatch("ready_o", 64'($sampled(ready)), 64'($sampled(m_state) == M_RUN));

  sleep_a: assert property (@(posedge clk) disable iff (!arst_n) sleep == (m_state == M_SLEEP))
    else report_mismatch("sleep_o", 64'($sampled(sleep)), 64'($sampled(m_state) == M_SLEEP));

  idle_enables_a: assert property (@(posedge clk) disable iff (!arst_n)
    !ex_valid |-> side_effects(ex_ctrl) == 7'b0)
    else report_mismatch("ex_ctrl_o enables when idle",
                         64'(side_effects($sampled(ex_ctrl))), '0);

  trap_enables_a: assert property (@(posedge clk) disable iff (!arst_n)
    ex_valid && (ex_ctrl.illegal_insn || ex_ctrl.ecall_insn || ex_ctrl.ebrk_insn)
    |-> side_effects(ex_ctrl) == 7'b0 && ex_ctrl.csr_op == CSR_OP_READ)
    else report_mismatch("ex_ctrl_o {enables, csr_op} on trap",
                         64'({side_effects($sampled(ex_ctrl)), $sampled(ex_ctrl.csr_op)}),
                         '0);

  ////////////////////////////////////////////////////////////
  // Clock and stimulus
  ////////////////////////////////////////////////////////////
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    int    wait_cycles;
    int    n;
    kind_e base;
    seed           = 32'hf206_1a1c;
    arst_n         = 1'b0;
    instr_valid    = 1'b0;
    instr_rdata    = '0;
    illegal_c_insn = 1'b0;
    irq            = 1'b0;
    cur_kind       = K_ILLEGAL;
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;

    for (n = 0; n < NUM_ACCEPT; n++) begin
      if (($random(seed) & 3) == 0) begin          // Bubble with a junk word
        instr_valid    = 1'b0;
        instr_rdata    = $random(seed);
        illegal_c_insn = 1'b0;
        irq            = (($random(seed) & 7) == 0);
        @(negedge clk);
      end
      cur_kind = kind_e'($unsigned($random(seed)) % 16);
      base     = (cur_kind == K_CFLAG) ? kind_e'($unsigned($random(seed)) % 14) : cur_kind;
      instr_valid    = 1'b1;
      instr_rdata    = instr_word(base);
      illegal_c_insn = (cur_kind == K_CFLAG);
      wait_cycles    = 0;
      // Word held until taken, irq pulses end any sleep
      do begin
        irq = (($random(seed) & 7) == 0);
        @(negedge clk);
        wait_cycles++;
        if (!ex_valid && wait_cycles >= ACCEPT_TIMEOUT) begin
          fail_run($sformatf("Instruction %0d was not accepted within %0d cycles",
                             n, ACCEPT_TIMEOUT));
        end
      end while (!ex_valid);
    end

    instr_valid    = 1'b0;
    illegal_c_insn = 1'b0;
    irq            = 1'b0;
    repeat (2) @(negedge clk);                     // Last record through the checks
    if (accepted_count == NUM_ACCEPT) begin
      $display("TEST OK");
      $finish;
    end else begin
      fail_run($sformatf("Model counted %0d accepted instructions, expected %0d",
                         accepted_count, NUM_ACCEPT));
    end
  end

endmodule
